// File: hdl/idma_pkg.sv
// ----------------------------------------
// Shared constants and types of the copy engine
// Bus width is fixed at one 32-bit word
// ----------------------------------------

`default_nettype none

package idma_pkg;

    // ----------------------------------------
    // Bus geometry
    // ----------------------------------------
    localparam int unsigned DataWidth   = 32;
    localparam int unsigned StrbWidth   = DataWidth / 8;
    localparam int unsigned OffsetWidth = $clog2(StrbWidth);

    // Error kind carried with each response
    typedef enum logic [1:0] {
        ERR_NONE            = 2'd0,
        ERR_ZERO_LENGTH     = 2'd1,
        ERR_OFFSET_MISMATCH = 2'd2
    } idma_err_e;

    localparam int unsigned ErrWidth = $bits(idma_err_e);

    // ----------------------------------------
    // Job word layout, low bits first
    // err, reject, last enable, first enable, beat count, word address
    // ----------------------------------------

    // Beat count must hold (offset + length) rounded up to whole beats
    function automatic int unsigned beat_width(input int unsigned len_w);
        return len_w - OffsetWidth + 1;
    endfunction

    function automatic int unsigned job_width(input int unsigned addr_w,
                                              input int unsigned len_w);
        return (addr_w - OffsetWidth) + beat_width(len_w) + 2 * StrbWidth + 1 + ErrWidth;
    endfunction

endpackage

`default_nettype wire

// File: hdl/idma_stream_fifo.sv
// ----------------------------------------
// Valid/ready FIFO on a registered circular buffer
// One cycle from push to output, no fall-through
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module idma_stream_fifo #(
    parameter int unsigned Width = 8,
    parameter int unsigned Depth = 2,
    localparam int unsigned PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1,
    localparam int unsigned UsageWidth = $clog2(Depth + 1)
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic [Width-1:0]      data_i,
    input  wire logic                  valid_i,
    output logic                       ready_o,
    output logic [Width-1:0]           data_o,
    output logic                       valid_o,
    input  wire logic                  ready_i,
    output logic [UsageWidth-1:0]      usage_o
);

    logic [Width-1:0]      mem_q [Depth];
    logic [PtrWidth-1:0]   wr_ptr_q;
    logic [PtrWidth-1:0]   rd_ptr_q;
    logic [UsageWidth-1:0] count_q;
    logic                  push;
    logic                  pop;

    assign ready_o = (count_q != UsageWidth'(Depth));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];
    assign usage_o = count_q;

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // ----------------------------------------
    // Pointers and fill level
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers meet only when empty or full, a push must never land on unread data
    a_no_overwrite: assert property (@(posedge clk_i) disable iff (reset_i)
        push |-> (wr_ptr_q != rd_ptr_q) || (count_q == '0));

endmodule

`default_nettype wire

// File: hdl/idma_burst_setup.sv
// ----------------------------------------
// Turns one request into one read job and one write job
// Purely combinational, both jobs are pushed in the same cycle
// Unequal source and destination offsets are rejected
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module idma_burst_setup import idma_pkg::*; #(
    parameter int unsigned AddrWidth = 24,
    parameter int unsigned LenWidth  = 16,
    localparam int unsigned JobWidth = job_width(AddrWidth, LenWidth)
) (
    input  wire logic                 req_valid_i,
    output logic                      req_ready_o,
    input  wire logic [AddrWidth-1:0] src_addr_i,
    input  wire logic [AddrWidth-1:0] dst_addr_i,
    input  wire logic [LenWidth-1:0]  length_i,
    output logic [JobWidth-1:0]       r_job_o,
    output logic                      r_job_valid_o,
    input  wire logic                 r_job_ready_i,
    output logic [JobWidth-1:0]       w_job_o,
    output logic                      w_job_valid_o,
    input  wire logic                 w_job_ready_i
);

    localparam int unsigned BeatWidth = beat_width(LenWidth);

    logic [OffsetWidth-1:0] src_off;
    logic [OffsetWidth-1:0] dst_off;
    logic [OffsetWidth-1:0] trailer;
    logic [LenWidth+1:0]    span;
    logic [BeatWidth-1:0]   beats;
    logic [StrbWidth-1:0]   be_first;
    logic [StrbWidth-1:0]   be_last;
    logic [StrbWidth-1:0]   be_first_job;
    logic [StrbWidth-1:0]   be_last_job;
    logic                   single;
    logic                   reject;
    idma_err_e              err;

    assign src_off = src_addr_i[OffsetWidth-1:0];
    assign dst_off = dst_addr_i[OffsetWidth-1:0];

    // Offset plus length, rounded up to whole beats
    assign span  = (LenWidth+2)'(length_i) + (LenWidth+2)'(src_off)
                 + (LenWidth+2)'(StrbWidth - 1);
    assign beats = BeatWidth'(span >> OffsetWidth);

    // Trailer of 0 means the last beat is full
    assign trailer  = length_i[OffsetWidth-1:0] + src_off;
    assign be_first = StrbWidth'({StrbWidth{1'b1}} << src_off);
    assign be_last  = (trailer == '0) ? {StrbWidth{1'b1}}
                                      : StrbWidth'(~({StrbWidth{1'b1}} << trailer));

    assign single       = (beats == BeatWidth'(1));
    assign be_first_job = single ? (be_first & be_last) : be_first;
    assign be_last_job  = single ? (be_first & be_last) : be_last;

    always_comb begin
        if (length_i == '0) begin
            err = ERR_ZERO_LENGTH;
        end else if (src_off != dst_off) begin
            err = ERR_OFFSET_MISMATCH;
        end else begin
            err = ERR_NONE;
        end
    end

    assign reject = (err != ERR_NONE);

    // ----------------------------------------
    // Stream fork into both job queues
    // ----------------------------------------
    assign req_ready_o   = r_job_ready_i & w_job_ready_i;
    assign r_job_valid_o = req_valid_i & req_ready_o;
    assign w_job_valid_o = req_valid_i & req_ready_o;

    assign r_job_o = {src_addr_i[AddrWidth-1:OffsetWidth], beats,
                      be_first_job, be_last_job, reject, err};
    assign w_job_o = {dst_addr_i[AddrWidth-1:OffsetWidth], beats,
                      be_first_job, be_last_job, reject, err};

    // An accepted job always moves at least one beat
    always_comb begin
        if (r_job_valid_o && r_job_ready_i) begin
            a_beats_nonzero: assert final (reject || beats != '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/idma_read_engine.sv
// ----------------------------------------
// Issues word reads for each job and forwards the returned data
// Reads are only issued while the data buffer has room for them
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module idma_read_engine import idma_pkg::*; #(
    parameter int unsigned AddrWidth   = 24,
    parameter int unsigned LenWidth    = 16,
    parameter int unsigned BufferDepth = 3,
    localparam int unsigned JobWidth   = job_width(AddrWidth, LenWidth),
    localparam int unsigned CntWidth   = $clog2(BufferDepth + 1)
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic [JobWidth-1:0]  job_i,
    input  wire logic                 job_valid_i,
    output logic                      job_ready_o,
    input  wire logic [CntWidth-1:0]  buf_usage_i,
    output logic                      rd_req_o,
    output logic [AddrWidth-1:0]      rd_addr_o,
    input  wire logic                 rd_gnt_i,
    input  wire logic                 rd_rvalid_i,
    input  wire logic [DataWidth-1:0] rd_rdata_i,
    output logic [DataWidth-1:0]      buf_data_o,
    output logic                      buf_valid_o,
    output logic                      busy_o
);

    localparam int unsigned WordWidth = AddrWidth - OffsetWidth;
    localparam int unsigned BeatWidth = beat_width(LenWidth);

    logic [WordWidth-1:0] job_addr;
    logic [WordWidth-1:0] addr_q;
    logic [BeatWidth-1:0] job_beats;
    logic [BeatWidth-1:0] remain_q;
    logic [CntWidth-1:0]  outstanding_q;
    logic                 job_reject;
    logic                 active_q;
    logic                 load;
    logic                 credit_ok;
    logic                 issue;

    assign job_addr   = job_i[JobWidth-1 -: WordWidth];
    assign job_beats  = job_i[JobWidth-WordWidth-1 -: BeatWidth];
    assign job_reject = job_i[ErrWidth];

    // Rejected jobs leave at once, others wait for the engine to go idle
    assign job_ready_o = job_valid_i & (job_reject | ~active_q);
    assign load        = job_valid_i & ~job_reject & ~active_q;

    // Credit counts both buffered words and reads still in flight
    assign credit_ok = (32'(buf_usage_i) + 32'(outstanding_q)) < BufferDepth;
    assign rd_req_o  = active_q & credit_ok;
    assign issue     = rd_req_o & rd_gnt_i;
    assign rd_addr_o = {addr_q, {OffsetWidth{1'b0}}};

    assign buf_data_o  = rd_rdata_i;
    assign buf_valid_o = rd_rvalid_i;
    assign busy_o      = active_q | (outstanding_q != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q      <= 1'b0;
            outstanding_q <= '0;
        end else begin
            if (load) begin
                active_q <= 1'b1;
            end else if (issue && remain_q == BeatWidth'(1)) begin
                active_q <= 1'b0;
            end
            if (issue && !rd_rvalid_i) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (rd_rvalid_i && !issue) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
        end
    end

    // Beat walker
    always_ff @(posedge clk_i) begin
        if (load) begin
            addr_q   <= job_addr;
            remain_q <= job_beats;
        end else if (issue) begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    a_rd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o));

endmodule

`default_nettype wire

// File: hdl/idma_write_engine.sv
// ----------------------------------------
// Writes buffered words with edge byte enables, one response per job
// A pending response blocks the next job, so responses stay in order
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module idma_write_engine import idma_pkg::*; #(
    parameter int unsigned AddrWidth = 24,
    parameter int unsigned LenWidth  = 16,
    localparam int unsigned JobWidth = job_width(AddrWidth, LenWidth)
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic [JobWidth-1:0]  job_i,
    input  wire logic                 job_valid_i,
    output logic                      job_ready_o,
    input  wire logic [DataWidth-1:0] buf_data_i,
    input  wire logic                 buf_valid_i,
    output logic                      buf_ready_o,
    output logic                      wr_req_o,
    output logic [AddrWidth-1:0]      wr_addr_o,
    output logic [DataWidth-1:0]      wr_data_o,
    output logic [StrbWidth-1:0]      wr_be_o,
    input  wire logic                 wr_gnt_i,
    output logic                      rsp_valid_o,
    input  wire logic                 rsp_ready_i,
    output logic                      rsp_error_o,
    output idma_err_e                 rsp_err_type_o,
    output logic                      busy_o
);

    localparam int unsigned WordWidth = AddrWidth - OffsetWidth;
    localparam int unsigned BeatWidth = beat_width(LenWidth);

    logic [WordWidth-1:0] addr_q;
    logic [BeatWidth-1:0] beats_q;
    logic [BeatWidth-1:0] idx_q;
    logic [StrbWidth-1:0] be_first_q;
    logic [StrbWidth-1:0] be_last_q;
    logic                 job_reject;
    idma_err_e            job_err;
    logic                 active_q;
    logic                 rsp_valid_q;
    logic                 rsp_error_q;
    idma_err_e            rsp_err_q;
    logic                 pop_job;
    logic                 last_beat;
    logic                 issue;

    assign job_err    = idma_err_e'(job_i[ErrWidth-1:0]);
    assign job_reject = job_i[ErrWidth];

    assign job_ready_o = job_valid_i & ~active_q & ~rsp_valid_q;
    assign pop_job     = job_ready_o;

    // ----------------------------------------
    // Beat issue
    // ----------------------------------------
    assign wr_req_o    = active_q & buf_valid_i;
    assign issue       = wr_req_o & wr_gnt_i;
    assign buf_ready_o = issue;
    assign last_beat   = (idx_q == beats_q - 1'b1);
    assign wr_addr_o   = {addr_q, {OffsetWidth{1'b0}}};
    assign wr_data_o   = buf_data_i;
    // First enable already holds the last one for single-beat jobs
    assign wr_be_o     = (idx_q == '0) ? be_first_q : (last_beat ? be_last_q : '1);

    assign rsp_valid_o    = rsp_valid_q;
    assign rsp_error_o    = rsp_error_q;
    assign rsp_err_type_o = rsp_err_q;
    assign busy_o         = active_q | rsp_valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
            rsp_error_q <= 1'b0;
            rsp_err_q   <= ERR_NONE;
        end else begin
            if (pop_job && !job_reject) begin
                active_q <= 1'b1;
            end else if (issue && last_beat) begin
                active_q <= 1'b0;
            end
            // Response register
            if (pop_job && job_reject) begin
                rsp_valid_q <= 1'b1;
                rsp_error_q <= 1'b1;
                rsp_err_q   <= job_err;
            end else if (issue && last_beat) begin
                rsp_valid_q <= 1'b1;
                rsp_error_q <= 1'b0;
                rsp_err_q   <= ERR_NONE;
            end else if (rsp_valid_q && rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_job) begin
            addr_q     <= job_i[JobWidth-1 -: WordWidth];
            beats_q    <= job_i[JobWidth-WordWidth-1 -: BeatWidth];
            be_first_q <= job_i[ErrWidth+1+StrbWidth +: StrbWidth];
            be_last_q  <= job_i[ErrWidth+1 +: StrbWidth];
            idx_q      <= '0;
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
            idx_q  <= idx_q + 1'b1;
        end
    end

    // Setup never builds an empty enable for an accepted job
    a_be_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_req_o |-> wr_be_o != '0);

endmodule

`default_nettype wire

// File: hdl/idma_backend.sv
// ----------------------------------------
// Single-channel 1D copy engine, one burst per request
// Source and destination must share the byte offset
// Responses come back in request order
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module idma_backend import idma_pkg::*; #(
    parameter int unsigned AddrWidth   = 24,
    parameter int unsigned LenWidth    = 16,
    parameter int unsigned JobDepth    = 2,
    parameter int unsigned BufferDepth = 3
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 req_valid_i,
    output logic                      req_ready_o,
    input  wire logic [AddrWidth-1:0] src_addr_i,
    input  wire logic [AddrWidth-1:0] dst_addr_i,
    input  wire logic [LenWidth-1:0]  length_i,
    output logic                      rsp_valid_o,
    input  wire logic                 rsp_ready_i,
    output logic                      rsp_error_o,
    output idma_err_e                 rsp_err_type_o,
    output logic                      rd_req_o,
    output logic [AddrWidth-1:0]      rd_addr_o,
    input  wire logic                 rd_gnt_i,
    input  wire logic                 rd_rvalid_i,
    input  wire logic [DataWidth-1:0] rd_rdata_i,
    output logic                      wr_req_o,
    output logic [AddrWidth-1:0]      wr_addr_o,
    output logic [DataWidth-1:0]      wr_data_o,
    output logic [StrbWidth-1:0]      wr_be_o,
    input  wire logic                 wr_gnt_i,
    output logic                      busy_o
);

    localparam int unsigned JobWidth = job_width(AddrWidth, LenWidth);
    localparam int unsigned BufWidth = $clog2(BufferDepth + 1);

    logic [JobWidth-1:0]  r_job, r_job_q;
    logic [JobWidth-1:0]  w_job, w_job_q;
    logic                 r_job_valid, r_job_ready, r_job_q_valid, r_job_q_ready;
    logic                 w_job_valid, w_job_ready, w_job_q_valid, w_job_q_ready;
    logic [DataWidth-1:0] buf_in_data, buf_out_data;
    logic                 buf_in_valid, buf_in_ready;
    logic                 buf_out_valid, buf_out_ready;
    logic [BufWidth-1:0]  buf_usage;
    logic                 r_busy, w_busy;

    idma_burst_setup #(.AddrWidth(AddrWidth), .LenWidth(LenWidth)) i_setup (
        .req_valid_i, .req_ready_o, .src_addr_i, .dst_addr_i, .length_i,
        .r_job_o (r_job), .r_job_valid_o (r_job_valid), .r_job_ready_i (r_job_ready),
        .w_job_o (w_job), .w_job_valid_o (w_job_valid), .w_job_ready_i (w_job_ready)
    );

    // ----------------------------------------
    // Decoupling queues and data buffer
    // ----------------------------------------
    idma_stream_fifo #(.Width(JobWidth), .Depth(JobDepth)) i_r_job (
        .clk_i, .reset_i, .data_i (r_job), .valid_i (r_job_valid), .ready_o (r_job_ready),
        .data_o (r_job_q), .valid_o (r_job_q_valid), .ready_i (r_job_q_ready), .usage_o ()
    );

    idma_stream_fifo #(.Width(JobWidth), .Depth(JobDepth)) i_w_job (
        .clk_i, .reset_i, .data_i (w_job), .valid_i (w_job_valid), .ready_o (w_job_ready),
        .data_o (w_job_q), .valid_o (w_job_q_valid), .ready_i (w_job_q_ready), .usage_o ()
    );

    idma_stream_fifo #(.Width(DataWidth), .Depth(BufferDepth)) i_buffer (
        .clk_i, .reset_i, .data_i (buf_in_data), .valid_i (buf_in_valid),
        .ready_o (buf_in_ready), .data_o (buf_out_data), .valid_o (buf_out_valid),
        .ready_i (buf_out_ready), .usage_o (buf_usage)
    );

    // ----------------------------------------
    // Datapath engines
    // ----------------------------------------
    idma_read_engine #(
        .AddrWidth(AddrWidth), .LenWidth(LenWidth), .BufferDepth(BufferDepth)
    ) i_read (
        .clk_i, .reset_i, .job_i (r_job_q), .job_valid_i (r_job_q_valid),
        .job_ready_o (r_job_q_ready), .buf_usage_i (buf_usage),
        .rd_req_o, .rd_addr_o, .rd_gnt_i, .rd_rvalid_i, .rd_rdata_i,
        .buf_data_o (buf_in_data), .buf_valid_o (buf_in_valid), .busy_o (r_busy)
    );

    idma_write_engine #(.AddrWidth(AddrWidth), .LenWidth(LenWidth)) i_write (
        .clk_i, .reset_i, .job_i (w_job_q), .job_valid_i (w_job_q_valid),
        .job_ready_o (w_job_q_ready), .buf_data_i (buf_out_data),
        .buf_valid_i (buf_out_valid), .buf_ready_o (buf_out_ready),
        .wr_req_o, .wr_addr_o, .wr_data_o, .wr_be_o, .wr_gnt_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_error_o, .rsp_err_type_o, .busy_o (w_busy)
    );

    assign busy_o = r_busy | w_busy | r_job_q_valid | w_job_q_valid | buf_out_valid;

    // Read credit must keep returned words from overflowing the buffer
    a_buf_room: assert property (@(posedge clk_i) disable iff (reset_i)
        buf_in_valid |-> buf_in_ready);

endmodule

`default_nettype wire

// File: testbench/tb_idma_backend.sv
// ----------------------------------------
// Testbench for the copy engine with its default parameters
// Destination writes must stay below 4 KiB
// ----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_idma_backend import idma_pkg::*;;

    localparam int NumEntries = 9;
    localparam int MaxBeats   = 6;
    localparam int DstSpan    = 4096;
    localparam int WatchdogNs = 2 * NumEntries * (MaxBeats + 40) * 20;
    localparam logic [7:0] Fill = 8'hEE;

    typedef struct packed {
        logic [23:0] src;
        logic [23:0] dst;
        logic [15:0] len;
        idma_err_e   kind;
    } entry_t;

    // Source, destination, byte length, expected error kind
    entry_t tests [NumEntries] = '{
        '{24'h012340, 24'h000100, 16'd16, ERR_NONE},
        '{24'h0A5001, 24'h000201, 16'd9,  ERR_NONE},
        '{24'h003004, 24'h000300, 16'd0,  ERR_ZERO_LENGTH},
        '{24'h004002, 24'h000401, 16'd8,  ERR_OFFSET_MISMATCH},
        '{24'h7F1003, 24'h000503, 16'd1,  ERR_NONE},
        '{24'h100002, 24'h000602, 16'd2,  ERR_NONE},
        '{24'hFFFFE8, 24'h000700, 16'd24, ERR_NONE},
        '{24'h055502, 24'h000802, 16'd19, ERR_NONE},
        '{24'h000001, 24'h000902, 16'd0,  ERR_ZERO_LENGTH}
    };

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        req_valid_i;
    logic        req_ready_o;
    logic [23:0] src_addr_i;
    logic [23:0] dst_addr_i;
    logic [15:0] length_i;
    logic        rsp_valid_o;
    logic        rsp_ready_i = 1'b0;
    logic        rsp_error_o;
    idma_err_e   rsp_err_type_o;
    logic        rd_req_o;
    logic [23:0] rd_addr_o;
    logic        rd_gnt_i = 1'b0;
    logic        rd_rvalid_i = 1'b0;
    logic [31:0] rd_rdata_i = 32'h0;
    logic        wr_req_o;
    logic [23:0] wr_addr_o;
    logic [31:0] wr_data_o;
    logic [3:0]  wr_be_o;
    logic        wr_gnt_i = 1'b0;
    logic        busy_o;

    logic [7:0]  dst_mem [DstSpan];
    logic [23:0] rd_pend_q [$];
    int          rd_due_q [$];
    logic [31:0] lcg_state = 32'd16;
    logic        reset_seen = 1'b1;
    int          cycle = 0;
    int          last_due = 0;
    int          delay;
    int          rsp_idx = 0;
    int          req_count = 0;
    int          rd_count = 0;
    int          wr_count = 0;

    idma_backend #(
        .AddrWidth(24), .LenWidth(16), .JobDepth(2), .BufferDepth(3)
    ) dut_i (
        .clk_i, .reset_i, .req_valid_i, .req_ready_o, .src_addr_i, .dst_addr_i, .length_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_error_o, .rsp_err_type_o,
        .rd_req_o, .rd_addr_o, .rd_gnt_i, .rd_rvalid_i, .rd_rdata_i,
        .wr_req_o, .wr_addr_o, .wr_data_o, .wr_be_o, .wr_gnt_i, .busy_o
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) reset_seen <= reset_i;

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // Source pattern that depends on every address bit
    function automatic logic [7:0] src_byte(input logic [23:0] a);
        return a[7:0] ^ {a[10:8], a[15:11]} ^ (a[23:16] + 8'h5a);
    endfunction

    function automatic logic [31:0] src_word(input logic [23:0] a);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = src_byte(a + 24'(b));
        end
        return w;
    endfunction

    // Number of 4-byte words that an accepted byte range touches
    function automatic int words_touched(input logic [23:0] addr, input logic [15:0] len,
                                         input idma_err_e kind);
        int first_word;
        int last_word;
        // A rejected request moves no word
        if (kind != ERR_NONE) begin
            return 0;
        end
        first_word = int'(addr) / 4;
        last_word  = (int'(addr) + int'(len) - 1) / 4;
        return last_word - first_word + 1;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic clear_dst();
        for (int k = 0; k < DstSpan; k++) begin
            dst_mem[k] = Fill;
        end
    endtask

    // Checks the whole 256-byte region of the entry against source bytes and fill
    task automatic check_entry(input entry_t t);
        logic [23:0] a;
        logic [7:0]  exp;
        for (int k = 0; k < 256; k++) begin
            a = {t.dst[23:8], 8'h00} + 24'(k);
            if (t.kind == ERR_NONE && a >= t.dst && a < t.dst + 24'(t.len)) begin
                exp = src_byte(t.src + (a - t.dst));
            end else begin
                exp = Fill;
            end
            check_value($sformatf("dst_mem[%0h]", a), 32'(dst_mem[a[11:0]]), 32'(exp));
        end
    endtask

    // Starts and ends on a falling edge
    task automatic send_request(input entry_t t);
        req_valid_i = 1'b1;
        src_addr_i  = t.src;
        dst_addr_i  = t.dst;
        length_i    = t.len;
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        req_count++;
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    // ----------------------------------------
    // Memory model and response sink
    // ----------------------------------------
    always @(negedge clk_i) begin
        if (!reset_seen) begin
            cycle++;
            if (rd_due_q.size() != 0 && rd_due_q[0] == cycle) begin
                rd_rvalid_i = 1'b1;
                rd_rdata_i  = src_word(rd_pend_q.pop_front());
                void'(rd_due_q.pop_front());
            end else begin
                rd_rvalid_i = 1'b0;
                rd_rdata_i  = 32'h0;
            end
            rd_gnt_i = (lcg_next() % 4) != 0;
            if (rd_req_o && rd_gnt_i) begin
                // Read data returns in order with at most one word per cycle
                delay    = 1 + lcg_next() % 3;
                last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
                rd_pend_q.push_back(rd_addr_o);
                rd_due_q.push_back(last_due);
                rd_count++;
            end
            wr_gnt_i = (lcg_next() % 4) != 0;
            if (wr_req_o && wr_gnt_i) begin
                if (wr_addr_o >= 24'(DstSpan)) begin
                    abort_run("A write went outside the destination window");
                end
                for (int b = 0; b < 4; b++) begin
                    if (wr_be_o[b]) begin
                        dst_mem[wr_addr_o[11:0] + 12'(b)] = wr_data_o[8*b +: 8];
                    end
                end
                wr_count++;
            end
            rsp_ready_i = (lcg_next() % 3) != 0;
            if (rsp_valid_o && rsp_ready_i) begin
                if (rsp_idx >= req_count) begin
                    abort_run("A response arrived with no open request");
                end
                check_value("rsp_error_o", 32'(rsp_error_o),
                            32'(tests[rsp_idx % NumEntries].kind != ERR_NONE));
                check_value("rsp_err_type_o", 32'(rsp_err_type_o),
                            32'(tests[rsp_idx % NumEntries].kind));
                rsp_idx++;
            end
        end
    end

    initial begin
        #(WatchdogNs);
        abort_run("Timeout while waiting for the DUT to finish");
    end

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        src_addr_i  = '0;
        dst_addr_i  = '0;
        length_i    = '0;
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
        check_value("req_ready_o", 32'(req_ready_o), 1);
        check_value("busy_o", 32'(busy_o), 0);
        check_value("rd_req_o", 32'(rd_req_o), 0);
        check_value("wr_req_o", 32'(wr_req_o), 0);
        check_value("rsp_valid_o", 32'(rsp_valid_o), 0);

        // One entry at a time
        for (int i = 0; i < NumEntries; i++) begin
            clear_dst();
            rd_count = 0;
            wr_count = 0;
            send_request(tests[i]);
            wait (rsp_idx == i + 1);
            @(negedge clk_i);
            check_value("busy_o", 32'(busy_o), 0);
            check_value("rd_req_o beats", 32'(rd_count),
                        32'(words_touched(tests[i].src, tests[i].len, tests[i].kind)));
            check_value("wr_req_o beats", 32'(wr_count),
                        32'(words_touched(tests[i].dst, tests[i].len, tests[i].kind)));
            check_entry(tests[i]);
        end

        // Whole table back-to-back
        clear_dst();
        for (int i = 0; i < NumEntries; i++) begin
            send_request(tests[i]);
        end
        wait (rsp_idx == 2 * NumEntries);
        @(negedge clk_i);
        check_value("busy_o", 32'(busy_o), 0);
        for (int i = 0; i < NumEntries; i++) begin
            check_entry(tests[i]);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/idma_pkg.sv
hdl/idma_stream_fifo.sv
hdl/idma_burst_setup.sv
hdl/idma_read_engine.sv
hdl/idma_write_engine.sv
hdl/idma_backend.sv
testbench/tb_idma_backend.sv

// File: run.sh
#!/bin/sh
# Builds the copy engine testbench with Verilator and runs it
# Exit status is nonzero when the build or the simulation fails

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_idma_backend -f project.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_idma_backend; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without errors"
exit 0
